// ==== cpuTypesPkg.sv ====
// CPU-wide types
// Operating mode, architectural register numbers and the decoded register
// record passed from the decode stage to rename

`include "decode_config.svh"

package cpuTypesPkg;

	// Privilege level, also used as the index of the banked stack pointer
	typedef enum logic [1:0]
	{
		OM_USER       = 2'd0,
		OM_SUPERVISOR = 2'd1,
		OM_HYPERVISOR = 2'd2,
		OM_MACHINE    = 2'd3
	} operatingModeT;

	// Architectural register number after banking
	typedef logic [`AREG_W-1:0] aregnoT;

	// Register specifiers of one instruction
	// rtz marks a discarded result, rtn a negated target
	typedef struct packed
	{
		aregnoT rt;
		logic   rtz;
		logic   rtn;
		aregnoT ra;
		aregnoT rb;
	} decodedRegsT;

endpackage

// ==== decodeChecker.sv ====
// Decode result checker
// Watches the decode stage outputs, pairs each result with the oldest
// expected entry and keeps the pass and fail counts

`timescale 1ns/10ps

module decodeChecker
	import cpuTypesPkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	input  logic        instrValid,
	input  logic        decValid,
	input  decodedRegsT dec,
	output int          passCount,
	output int          failCount
);

	// Expected entries in strobe order
	string       nameQ [$];
	decodedRegsT wantQ [$];

	// instrValid as sampled at the previous rising edge
	logic        strobeSeen;
	// Set when the previous rising edge was still in reset
	logic        resetSeen;

	string       name;
	decodedRegsT want;

	// Called by the testbench in the same cycle as the matching strobe
	function automatic void pushExpected(input string testName, input decodedRegsT regs);
		nameQ.push_back(testName);
		wantQ.push_back(regs);
	endfunction

	function automatic int pendingCount();
		return wantQ.size();
	endfunction

	// Outputs are sampled before the edge updates them, so they show the
	// result of the strobe taken one edge earlier
	always @(posedge clk)
	begin
		if (!rstN)
		begin
			passCount = 0;
			failCount = 0;
			nameQ.delete();
			wantQ.delete();
			strobeSeen = 1'b0;
		end
		else
		begin
			if (resetSeen && ((decValid !== 1'b0) || (dec !== '0)))
			begin
				$display("reset did not clear decValid and dec");
				failCount++;
			end
			// decValid must follow instrValid by exactly one cycle
			if (!resetSeen && (decValid !== strobeSeen))
			begin
				$display("decValid was %b one cycle after instrValid was %b",
					decValid, strobeSeen);
				failCount++;
			end
			if (decValid === 1'b1)
			begin
				if (wantQ.size() == 0)
				begin
					$display("a decoded result came out with no instruction waiting for it");
					failCount++;
				end
				else
				begin
					name = nameQ.pop_front();
					want = wantQ.pop_front();
					if (dec === want)
					begin
						$display("pass %s", name);
						passCount++;
					end
					else
					begin
						$display("error %s: expected %h, actual %h", name, want, dec);
						failCount++;
					end
				end
			end
			strobeSeen = instrValid;
		end
		resetSeen = !rstN;
	end

endmodule

// ==== decodeInstrPkg.sv ====
// Instruction format definitions
// Opcode and function encodings plus the layouts that one instruction word
// can be read through; the opcode sits in bits 6:0 in every layout

`include "decode_config.svh"

package decodeInstrPkg;

	// ======================================================================
	// Encodings
	// ======================================================================

	// Major opcodes seen by the register decoders
	typedef enum logic [6:0]
	{
		OP_R2    = 7'h02,
		OP_ADDI  = 7'h04,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_SHIFT = 7'h0C,
		OP_CSR   = 7'h0F,
		OP_MOV   = 7'h12,
		OP_LDx   = 7'h20,
		OP_STx   = 7'h24,
		OP_Bcc   = 7'h28,
		OP_BSR   = 7'h30,
		OP_JSR   = 7'h31,
		OP_RTD   = 7'h34,
		OP_DBRA  = 7'h35,
		OP_MCB   = 7'h38
	} opcodeT;

	// Function codes of the register-register group
	// Codes not listed here are undefined and write no register
	typedef enum logic [6:0]
	{
		FN_ADD  = 7'h04,
		FN_SUB  = 7'h05,
		FN_AND  = 7'h08,
		FN_OR   = 7'h09,
		FN_EOR  = 7'h0A,
		FN_SLT  = 7'h10,
		FN_SLTU = 7'h11,
		FN_ZSEQ = 7'h18,
		FN_MUL  = 7'h20
	} funcT;

	// ======================================================================
	// Formats
	// ======================================================================

	// A register field carries a negate bit above the register number
	typedef struct packed
	{
		logic       n;
		logic [5:0] num;
	} regFieldT;

	// Generic view, only good for finding the opcode
	typedef struct packed
	{
		logic [`INSTR_W-8:0] rest;
		opcodeT              opcode;
	} anyFmtT;

	// Register-register layout, also used by immediates, loads and stores
	// The top bit selects the raw register form of MOV
	typedef struct packed
	{
		logic                 movAlt;
		logic [`INSTR_W-37:0] rest;
		funcT                 func;
		regFieldT             rb;
		regFieldT             ra;
		regFieldT             rt;
		opcodeT               opcode;
	} r2FmtT;

	// Conditional branch, inc nonzero means Ra is also updated
	typedef struct packed
	{
		logic [`INSTR_W-24:0] disp;
		logic [1:0]           inc;
		regFieldT             rb;
		regFieldT             ra;
		opcodeT               opcode;
	} brFmtT;

	// Multi-way call/branch, lk saves the return address in the link register
	typedef struct packed
	{
		logic [`INSTR_W-9:0] target;
		logic                lk;
		opcodeT              opcode;
	} mcbFmtT;

	// One fetched word, read through whichever layout the opcode calls for
	typedef union packed
	{
		anyFmtT any;
		r2FmtT  r2;
		brFmtT  br;
		mcbFmtT mcb;
	} instructionT;

endpackage

// ==== decodeRt.sv ====
// Target register decoder
// Finds the architectural destination of an instruction, maps the stack
// pointer to its per-mode copy and flags zero and negated targets

`timescale 1ns/10ps

`include "decode_config.svh"

module decodeRt
	import cpuTypesPkg::*;
	import decodeInstrPkg::*;
(
	input  instructionT   instr,
	input  operatingModeT om,
	output aregnoT        rt,
	output logic          rtz,
	output logic          rtn
);

	// Target before stack pointer banking
	aregnoT rtRaw;
	// Raw register form of MOV bypasses banking
	logic movRaw;

	// ======================================================================
	// Target selection
	// ======================================================================

	always_comb
	begin
		rtRaw = '0;
		case (instr.any.opcode)
		OP_R2:
			begin
				// Only defined functions write the Rt field
				if (instr.r2.func inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_EOR,
					FN_SLT, FN_SLTU, FN_ZSEQ, FN_MUL})
					rtRaw = aregnoT'(instr.r2.rt.num);
				else
					rtRaw = '0;
			end
		OP_ADDI, OP_ANDI, OP_ORI:
			rtRaw = aregnoT'(instr.r2.rt.num);
		OP_SHIFT, OP_CSR, OP_MOV:
			rtRaw = aregnoT'(instr.r2.rt.num);
		OP_LDx:
			rtRaw = aregnoT'(instr.r2.rt.num);
		// Calls place the return address in Rt
		OP_BSR, OP_JSR:
			rtRaw = aregnoT'(instr.r2.rt.num);
		OP_MCB:
			rtRaw = instr.mcb.lk ? aregnoT'(`LINK_REG) : '0;
		// Return pops the stack so the stack pointer is written
		OP_RTD:
			rtRaw = aregnoT'(`SP_REG);
		// Decrement and branch counts down in the loop register
		OP_DBRA:
			rtRaw = aregnoT'(`LOOP_REG);
		OP_Bcc:
			rtRaw = (|instr.br.inc) ? aregnoT'(instr.br.ra.num) : '0;
		// Stores and anything unknown write nothing
		default:
			rtRaw = '0;
		endcase
	end

	// ======================================================================
	// Banking and flags
	// ======================================================================

	assign movRaw = (instr.any.opcode == OP_MOV) && instr.r2.movAlt;

	always_comb
	begin
		rt = rtRaw;
		// Register 31 names the stack pointer of the current mode
		if ((rtRaw == aregnoT'(`SP_REG)) && !movRaw)
			rt = aregnoT'(`SP_BANK_BASE) + aregnoT'(om);
	end

	// BSR reuses the negate bit position, so it never negates
	assign rtn = (instr.any.opcode == OP_BSR) ? 1'b0 : instr.r2.rt.n;

	// A zero target means the result is discarded
	assign rtz = (rt == '0);

endmodule

// ==== decodeSrcRegs.sv ====
// Source register decoder
// Picks the Ra and Rb operands of an instruction and maps the stack
// pointer to the copy belonging to the current operating mode

`timescale 1ns/10ps

`include "decode_config.svh"

module decodeSrcRegs
	import cpuTypesPkg::*;
	import decodeInstrPkg::*;
(
	input  instructionT   instr,
	input  operatingModeT om,
	output aregnoT        ra,
	output aregnoT        rb
);

	// Register numbers straight from the fields
	aregnoT raRaw;
	aregnoT rbRaw;

	// Swap register 31 for the per-mode stack pointer
	function automatic aregnoT bankSp(input aregnoT r, input operatingModeT m);
		if (r == aregnoT'(`SP_REG))
			return aregnoT'(`SP_BANK_BASE) + aregnoT'(m);
		return r;
	endfunction

	always_comb
	begin
		case (instr.any.opcode)
		// These carry no Ra field
		OP_MCB, OP_RTD, OP_DBRA:
			raRaw = '0;
		OP_Bcc:
			raRaw = aregnoT'(instr.br.ra.num);
		default:
			raRaw = aregnoT'(instr.r2.ra.num);
		endcase

		// Only register-register, store and branch forms read Rb
		case (instr.any.opcode)
		OP_R2, OP_STx:
			rbRaw = aregnoT'(instr.r2.rb.num);
		OP_Bcc:
			rbRaw = aregnoT'(instr.br.rb.num);
		default:
			rbRaw = '0;
		endcase
	end

	assign ra = bankSp(raRaw, om);
	assign rb = bankSp(rbRaw, om);

endmodule

// ==== decode_config.svh ====
// Decode stage configuration
// Word widths and the fixed register numbers shared by the register decoders
// and the instruction format package

`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Width of one fetched instruction word
`define INSTR_W 64

// Width of an architectural register number, wide enough for the banked copies
`define AREG_W 8

// Fixed register numbers used by the implied-target instructions
`define LINK_REG 59
`define LOOP_REG 55
`define SP_REG 31

// First of the four per-mode stack pointer copies, indexed by operating mode
`define SP_BANK_BASE 32

`endif

// ==== files.f ====
+incdir+.
cpuTypesPkg.sv
decodeInstrPkg.sv
decodeRt.sv
decodeSrcRegs.sv
instructionDecoder.sv
decodeChecker.sv
tbDecode.sv

// ==== instructionDecoder.sv ====
// Register specifier decode stage
// Runs the target and source decoders on the incoming word and registers
// the combined result one cycle after the valid strobe

`timescale 1ns/10ps

module instructionDecoder
	import cpuTypesPkg::*;
	import decodeInstrPkg::*;
(
	input  logic          clk,
	input  logic          rstN,
	input  logic          instrValid,
	input  instructionT   instr,
	input  operatingModeT om,
	output logic          decValid,
	output decodedRegsT   dec
);

	// Combinational decoder outputs
	aregnoT rtC;
	logic   rtzC;
	logic   rtnC;
	aregnoT raC;
	aregnoT rbC;

	// Merged result waiting for the clock edge
	decodedRegsT decNext;

	// ======================================================================
	// Decoders
	// ======================================================================

	decodeRt uRt
	(
		.instr (instr),
		.om    (om),
		.rt    (rtC),
		.rtz   (rtzC),
		.rtn   (rtnC)
	);

	decodeSrcRegs uSrc
	(
		.instr (instr),
		.om    (om),
		.ra    (raC),
		.rb    (rbC)
	);

	assign decNext = '{rt: rtC, rtz: rtzC, rtn: rtnC, ra: raC, rb: rbC};

	// ======================================================================
	// Output register
	// ======================================================================

	// Each strobe produces exactly one cycle of decValid, no stalling
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			decValid <= 1'b0;
			dec      <= '0;
		end
		else
		begin
			decValid <= instrValid;
			// Hold the last result while idle
			if (instrValid)
				dec <= decNext;
		end
	end

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the register decode testbench with Verilator and runs it.
# The run passes only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module tbDecode -f files.f -o tbDecode
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tbDecode > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
else
	exit 1
fi

// ==== tbDecode.sv ====
// Register decode testbench
// Drives a table of instruction words into the decode stage on the falling
// clock edge and hands the expected registers to the result checker

`timescale 1ns/10ps

`include "decode_config.svh"

module tbDecode
	import cpuTypesPkg::*;
	import decodeInstrPkg::*;
();

	localparam int maxRows = 32;
	// Cycles the checker may take to consume the last results
	localparam int drainLimit = 20;
	// Bits 62:35 are read by neither decoder in any format
	localparam int restW = `INSTR_W - 36;

	logic          clk;
	logic          rstN;
	logic          instrValid;
	instructionT   instr;
	operatingModeT om;
	logic          decValid;
	decodedRegsT   dec;
	int            passCount;
	int            failCount;

	// One stimulus table entry per test
	// rowGap holds the idle cycles that follow the entry
	string         rowName [maxRows];
	instructionT   rowInstr [maxRows];
	operatingModeT rowOm [maxRows];
	decodedRegsT   rowExp [maxRows];
	int            rowGap [maxRows];
	int            rowCount;

	int            seed;
	int            waitCount;
	logic          timedOut;

	instructionDecoder uut
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.om         (om),
		.decValid   (decValid),
		.dec        (dec)
	);

	decodeChecker resultCheck
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.decValid   (decValid),
		.dec        (dec),
		.passCount  (passCount),
		.failCount  (failCount)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	// ======================================================================
	// Instruction and result builders
	// ======================================================================

	// Register fields are {negate, number}
	function automatic instructionT mkR2(input opcodeT op, input logic [6:0] rt,
		input logic [6:0] ra, input logic [6:0] rb, input funcT fn, input logic alt);
		instructionT w;
		w = '0;
		w.r2.opcode = op;
		w.r2.rt     = rt;
		w.r2.ra     = ra;
		w.r2.rb     = rb;
		w.r2.func   = fn;
		w.r2.movAlt = alt;
		return w;
	endfunction

	function automatic instructionT mkBr(input logic [6:0] ra, input logic [6:0] rb,
		input logic [1:0] inc);
		instructionT w;
		w = '0;
		w.br.opcode = OP_Bcc;
		w.br.ra     = ra;
		w.br.rb     = rb;
		w.br.inc    = inc;
		return w;
	endfunction

	function automatic instructionT mkMcb(input logic lk);
		instructionT w;
		w = '0;
		w.mcb.opcode = OP_MCB;
		w.mcb.lk     = lk;
		return w;
	endfunction

	function automatic decodedRegsT decodedRegs(input int rt, input int rtz, input int rtn,
		input int ra, input int rb);
		decodedRegsT d;
		d.rt  = aregnoT'(rt);
		d.rtz = (rtz != 0);
		d.rtn = (rtn != 0);
		d.ra  = aregnoT'(ra);
		d.rb  = aregnoT'(rb);
		return d;
	endfunction

	function automatic void addRow(input string name, input instructionT ins,
		input operatingModeT m, input decodedRegsT want, input int gap);
		instructionT w;
		w = ins;
		// Noise in the unread bits must leave every result unchanged
		w.r2.rest = restW'($random(seed));
		rowName[rowCount]  = name;
		rowInstr[rowCount] = w;
		rowOm[rowCount]    = m;
		rowExp[rowCount]   = want;
		rowGap[rowCount]   = gap;
		rowCount++;
	endfunction

	// ======================================================================
	// Stimulus table
	// ======================================================================

	// Expected values are given as rt, rtz, rtn, ra and rb
	// The banked stack pointer is 32 plus the mode
	function automatic void loadTable();
		addRow("add", mkR2(OP_R2, 7'd5, 7'd6, 7'd7, FN_ADD, 1'b0),
			OM_USER, decodedRegs(5, 0, 0, 6, 7), 1);
		addRow("mulNeg", mkR2(OP_R2, {1'b1, 6'd12}, 7'd3, 7'd4, FN_MUL, 1'b0),
			OM_SUPERVISOR, decodedRegs(12, 0, 1, 3, 4), 0);
		addRow("and", mkR2(OP_R2, 7'd40, 7'd41, 7'd42, FN_AND, 1'b0),
			OM_USER, decodedRegs(40, 0, 0, 41, 42), 0);
		addRow("eorNeg", mkR2(OP_R2, {1'b1, 6'd63}, 7'd62, 7'd61, FN_EOR, 1'b0),
			OM_HYPERVISOR, decodedRegs(63, 0, 1, 62, 61), 0);
		addRow("slt", mkR2(OP_R2, 7'd26, 7'd27, 7'd28, FN_SLT, 1'b0),
			OM_SUPERVISOR, decodedRegs(26, 0, 0, 27, 28), 0);
		addRow("sltu", mkR2(OP_R2, 7'd29, 7'd30, 7'd1, FN_SLTU, 1'b0),
			OM_MACHINE, decodedRegs(29, 0, 0, 30, 1), 1);
		addRow("r2Undef", mkR2(OP_R2, 7'd9, 7'd1, 7'd2, funcT'(7'h7f), 1'b0),
			OM_USER, decodedRegs(0, 1, 0, 1, 2), 2);
		addRow("addi", mkR2(OP_ADDI, 7'd10, 7'd11, 7'd12, FN_ADD, 1'b0),
			OM_USER, decodedRegs(10, 0, 0, 11, 0), 0);
		addRow("andi", mkR2(OP_ANDI, 7'd23, 7'd24, 7'd25, FN_ADD, 1'b0),
			OM_USER, decodedRegs(23, 0, 0, 24, 0), 0);
		addRow("oriZero", mkR2(OP_ORI, 7'd0, 7'd2, 7'd3, FN_ADD, 1'b0),
			OM_USER, decodedRegs(0, 1, 0, 2, 0), 1);
		addRow("shift", mkR2(OP_SHIFT, 7'd14, 7'd15, 7'd16, FN_ADD, 1'b0),
			OM_USER, decodedRegs(14, 0, 0, 15, 0), 0);
		addRow("csr", mkR2(OP_CSR, 7'd20, 7'd21, 7'd22, FN_ADD, 1'b0),
			OM_MACHINE, decodedRegs(20, 0, 0, 21, 0), 1);
		addRow("ldSp", mkR2(OP_LDx, 7'd22, 7'd31, 7'd5, FN_ADD, 1'b0),
			OM_HYPERVISOR, decodedRegs(22, 0, 0, 34, 0), 0);
		addRow("stSp", mkR2(OP_STx, 7'd8, 7'd30, 7'd31, FN_ADD, 1'b0),
			OM_MACHINE, decodedRegs(0, 1, 0, 30, 35), 2);
		addRow("bsrNeg", mkR2(OP_BSR, {1'b1, 6'd1}, 7'd5, 7'd6, FN_ADD, 1'b0),
			OM_USER, decodedRegs(1, 0, 0, 5, 0), 0);
		addRow("jsrNeg", mkR2(OP_JSR, {1'b1, 6'd2}, 7'd3, 7'd4, FN_ADD, 1'b0),
			OM_USER, decodedRegs(2, 0, 1, 3, 0), 1);
		addRow("mcbLink", mkMcb(1'b1), OM_USER, decodedRegs(59, 0, 0, 0, 0), 0);
		addRow("mcbNoLink", mkMcb(1'b0), OM_USER, decodedRegs(0, 1, 0, 0, 0), 1);
		addRow("rtdUser", mkR2(OP_RTD, 7'd3, 7'd9, 7'd10, FN_ADD, 1'b0),
			OM_USER, decodedRegs(32, 0, 0, 0, 0), 0);
		addRow("rtdMachine", mkR2(OP_RTD, 7'd3, 7'd9, 7'd10, FN_ADD, 1'b0),
			OM_MACHINE, decodedRegs(35, 0, 0, 0, 0), 0);
		addRow("dbra", mkR2(OP_DBRA, 7'd3, 7'd9, 7'd10, FN_ADD, 1'b0),
			OM_SUPERVISOR, decodedRegs(55, 0, 0, 0, 0), 1);
		addRow("bccInc", mkBr(7'd17, 7'd18, 2'd2), OM_USER, decodedRegs(17, 0, 0, 17, 18), 0);
		addRow("bccNoInc", mkBr(7'd31, 7'd19, 2'd0),
			OM_SUPERVISOR, decodedRegs(0, 1, 0, 33, 19), 1);
		addRow("bccSp", mkBr(7'd31, 7'd31, 2'd1),
			OM_HYPERVISOR, decodedRegs(34, 0, 0, 34, 34), 0);
		addRow("subSp", mkR2(OP_R2, 7'd31, 7'd31, 7'd31, FN_SUB, 1'b0),
			OM_USER, decodedRegs(32, 0, 0, 32, 32), 0);
		addRow("orSp", mkR2(OP_R2, 7'd31, 7'd4, 7'd5, FN_OR, 1'b0),
			OM_SUPERVISOR, decodedRegs(33, 0, 0, 4, 5), 1);
		addRow("movSp", mkR2(OP_MOV, 7'd31, 7'd31, 7'd7, FN_ADD, 1'b0),
			OM_HYPERVISOR, decodedRegs(34, 0, 0, 34, 0), 0);
		// The raw form of MOV reaches register 31 itself
		addRow("movRaw", mkR2(OP_MOV, 7'd31, 7'd6, 7'd7, FN_ADD, 1'b1),
			OM_MACHINE, decodedRegs(31, 0, 0, 6, 0), 2);
		addRow("zseqNegSp", mkR2(OP_R2, {1'b1, 6'd31}, 7'd0, 7'd0, FN_ZSEQ, 1'b0),
			OM_MACHINE, decodedRegs(35, 0, 1, 0, 0), 0);
	endfunction

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial
	begin
		seed       = 32'hab63b98d;
		rowCount   = 0;
		timedOut   = 1'b0;
		clk        = 1'b0;
		rstN       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		om         = OM_USER;
		loadTable();

		repeat (16) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		// Rows with a gap of 0 are strobed back to back
		for (int i = 0; i < rowCount; i++)
		begin
			instrValid = 1'b1;
			instr      = rowInstr[i];
			om         = rowOm[i];
			resultCheck.pushExpected(rowName[i], rowExp[i]);
			@(negedge clk);
			instrValid = 1'b0;
			repeat (rowGap[i]) @(negedge clk);
		end

		waitCount = 0;
		while ((resultCheck.pendingCount() != 0) && (waitCount < drainLimit))
		begin
			@(negedge clk);
			waitCount++;
		end
		if (resultCheck.pendingCount() != 0)
		begin
			$display("timeout: %0d decoded results never appeared",
				resultCheck.pendingCount());
			timedOut = 1'b1;
		end
		// One idle edge more so that a stray decValid is caught
		@(negedge clk);

		$display("tests passed %0d, failed %0d, of %0d", passCount, failCount, rowCount);
		if ((failCount == 0) && (passCount == rowCount) && !timedOut)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
